// ==== Bender.yml ====
package:
  name: tmu_texcache

sources:
  - rtl/tmu_pkg.sv
  - rtl/tmu_tdpram.sv
  - rtl/tmu_qpram.sv
  - rtl/tmu_line_fill.sv
  - rtl/tmu_bilinear_filter.sv
  - rtl/tmu_texcache_top.sv
  - target: simulation
    files:
      - test/tb_tmu_texcache.sv

// ==== rtl/tmu_bilinear_filter.sv ====
// ------------------------------
// Bilinear texel filter
// ------------------------------
module tmu_bilinear_filter (
	input  logic                             sys_clk,
	input  logic                             rst_n,

	input  logic                             fetch, // one texel request per strobe
	input  logic [tmu_pkg::TEX_SIDE_LOG2-1:0] tex_x,
	input  logic [tmu_pkg::TEX_SIDE_LOG2-1:0] tex_y,
	input  logic [tmu_pkg::FRAC_W-1:0]        frac_x,
	input  logic [tmu_pkg::FRAC_W-1:0]        frac_y,

	output logic                             re, // RAM read, same cycle as fetch
	output logic [tmu_pkg::TEX_DEPTH-1:0]     raa, // texel (x, y)
	output logic [tmu_pkg::TEX_DEPTH-1:0]     rab, // texel (x+1, y)
	output logic [tmu_pkg::TEX_DEPTH-1:0]     rac, // texel (x, y+1)
	output logic [tmu_pkg::TEX_DEPTH-1:0]     rad, // texel (x+1, y+1)
	input  logic [tmu_pkg::TEXEL_W-1:0]       rda,
	input  logic [tmu_pkg::TEXEL_W-1:0]       rdb,
	input  logic [tmu_pkg::TEXEL_W-1:0]       rdc,
	input  logic [tmu_pkg::TEXEL_W-1:0]       rdd,

	output logic                             out_valid, // three cycles after fetch
	output logic [tmu_pkg::TEXEL_W-1:0]       out_pixel
);

	localparam int CH_W = 6; // green is the widest channel
	localparam int ONE = 1 << tmu_pkg::FRAC_W; // weight of a whole texel
	localparam int H_W = CH_W + tmu_pkg::FRAC_W; // horizontal blend width
	localparam int V_W = H_W + tmu_pkg::FRAC_W; // vertical blend width before the shift

	logic [tmu_pkg::TEX_SIDE_LOG2-1:0] x1; // neighbour coordinates, wrapping at 32
	logic [tmu_pkg::TEX_SIDE_LOG2-1:0] y1;
	logic [2:0] valid_q; // one bit per pipeline stage
	logic [tmu_pkg::FRAC_W-1:0] fx_q; // fractions aligned with the RAM output
	logic [tmu_pkg::FRAC_W-1:0] fy_q;
	logic [tmu_pkg::FRAC_W-1:0] fy_q2; // vertical weight aligned with stage 1
	logic [2:0][CH_W-1:0] ch_a; // channels of each texel, index 2 is red
	logic [2:0][CH_W-1:0] ch_b;
	logic [2:0][CH_W-1:0] ch_c;
	logic [2:0][CH_W-1:0] ch_d;
	logic [2:0][V_W-1:0] h_top; // combinational horizontal blends
	logic [2:0][V_W-1:0] h_bot;
	logic [2:0][H_W-1:0] top_q; // stage 1 registers
	logic [2:0][H_W-1:0] bot_q;
	logic [2:0][V_W-1:0] v_sum; // combinational vertical blend

	// red and blue get a zero on top so all channels share one datapath
	function automatic logic [2:0][CH_W-1:0] split_rgb(input logic [tmu_pkg::TEXEL_W-1:0] t);
		return {1'b0, t[15:11], t[10:5], 1'b0, t[4:0]};
	endfunction

	// p weighted by (64 - w) plus q weighted by w
	function automatic logic [V_W-1:0] blend(
		input logic [H_W-1:0]            p,
		input logic [H_W-1:0]            q,
		input logic [tmu_pkg::FRAC_W-1:0] w
	);
		logic [tmu_pkg::FRAC_W:0] w_inv;
		w_inv = (tmu_pkg::FRAC_W + 1)'(ONE) - {1'b0, w}; // reaches 64 when w is zero
		return V_W'(p) * w_inv + V_W'(q) * w;
	endfunction

	assign x1 = tex_x + 1'b1;
	assign y1 = tex_y + 1'b1;

	// byte address is (y * 32 + x) * 2
	assign re = fetch;
	assign raa = {tex_y, tex_x, 1'b0};
	assign rab = {tex_y, x1, 1'b0};
	assign rac = {y1, tex_x, 1'b0};
	assign rad = {y1, x1, 1'b0};

	assign ch_a = split_rgb(rda);
	assign ch_b = split_rgb(rdb);
	assign ch_c = split_rgb(rdc);
	assign ch_d = split_rgb(rdd);

	always_comb begin
		for (int i = 0; i < 3; i++) begin
			h_top[i] = blend(H_W'(ch_a[i]), H_W'(ch_b[i]), fx_q);
			h_bot[i] = blend(H_W'(ch_c[i]), H_W'(ch_d[i]), fx_q);
			v_sum[i] = blend(top_q[i], bot_q[i], fy_q2); // at most 63 * 64 * 64, fits V_W
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[1:0], fetch}; // RAM, stage 1, stage 2
		end
	end

	always_ff @(posedge sys_clk) begin
		fx_q <= frac_x;
		fy_q <= frac_y;
		fy_q2 <= fy_q;
		for (int i = 0; i < 3; i++) begin
			top_q[i] <= h_top[i][H_W-1:0]; // a horizontal blend never exceeds 63 * 64
			bot_q[i] <= h_bot[i][H_W-1:0];
		end
		// divide by 64 * 64 by dropping the low bits, then repack as RGB565
		out_pixel <= {v_sum[2][2*tmu_pkg::FRAC_W +: 5],
			v_sum[1][2*tmu_pkg::FRAC_W +: 6],
			v_sum[0][2*tmu_pkg::FRAC_W +: 5]};
	end

	assign out_valid = valid_q[2];

endmodule

// ==== rtl/tmu_line_fill.sv ====
// ------------------------------
// Cache line fill engine
// ------------------------------
module tmu_line_fill (
	input  logic                          sys_clk,
	input  logic                          rst_n,

	input  logic                          fill_start, // one-cycle pulse with the line index
	input  logic [tmu_pkg::LINE_IDX_W-1:0] fill_line, // byte address divided by 32
	input  logic                          fill_valid, // one beat of the line
	input  logic [tmu_pkg::BEAT_W-1:0]     fill_data,
	output logic                          fill_busy, // high from after fill_start through the write

	output logic                          we, // one-cycle line write
	output logic [tmu_pkg::TEX_DEPTH-1:0]  wa,
	output logic [tmu_pkg::LINE_W-1:0]     wd
);

	localparam int CNT_W = $clog2(tmu_pkg::BEATS_PER_LINE);

	tmu_pkg::fill_state_e state;
	logic [CNT_W-1:0] beat_cnt; // beats taken so far in this line
	logic [tmu_pkg::LINE_IDX_W-1:0] line_q; // line index latched at fill_start
	logic [tmu_pkg::LINE_W-1:0] line_data; // beats shift in from the bottom

	always_ff @(posedge sys_clk) begin
		if (!rst_n) begin
			state <= tmu_pkg::FILL_IDLE;
			beat_cnt <= '0;
		end else begin
			case (state)
				tmu_pkg::FILL_IDLE: begin
					if (fill_start) begin
						state <= tmu_pkg::FILL_GATHER; // stray fill_valid here is dropped
						beat_cnt <= '0;
					end
				end
				tmu_pkg::FILL_GATHER: begin
					if (fill_valid) begin
						beat_cnt <= beat_cnt + 1'b1; // wraps back to zero after the last beat
						if (beat_cnt == CNT_W'(tmu_pkg::BEATS_PER_LINE - 1)) begin
							state <= tmu_pkg::FILL_WRITE;
						end
					end
				end
				tmu_pkg::FILL_WRITE: state <= tmu_pkg::FILL_IDLE; // write lasts one cycle
				default: state <= tmu_pkg::FILL_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == tmu_pkg::FILL_IDLE && fill_start) begin
			line_q <= fill_line;
		end
		if (state == tmu_pkg::FILL_GATHER && fill_valid) begin
			// after four beats the first one has reached the top of the line
			line_data <= {line_data[tmu_pkg::LINE_W-tmu_pkg::BEAT_W-1:0], fill_data};
		end
	end

	assign fill_busy = (state != tmu_pkg::FILL_IDLE);
	assign we = (state == tmu_pkg::FILL_WRITE);
	assign wa = {line_q, {tmu_pkg::LINE_OFS_W{1'b0}}}; // line aligned byte address
	assign wd = line_data;

endmodule

// ==== rtl/tmu_pkg.sv ====
// ------------------------------
// Texture unit shared constants
// ------------------------------
package tmu_pkg;

	localparam int TEX_DEPTH = 11; // log2 of the tile size in bytes (2048)
	localparam int TEX_SIDE_LOG2 = 5; // tile is 32 texels on a side
	localparam int TEXEL_W = 16; // one RGB565 texel
	localparam int FRAC_W = 6; // a weight of 64 stands for one whole

	localparam int LINE_W = 256; // one cache line holds sixteen texels
	localparam int BEAT_W = 64; // memory delivers a line in 64-bit beats
	localparam int BEATS_PER_LINE = LINE_W / BEAT_W; // four beats per line

	localparam int LINE_OFS_W = $clog2(LINE_W / 8); // byte offset bits inside a line
	localparam int LINE_IDX_W = TEX_DEPTH - LINE_OFS_W; // lines in a tile, 64 of them

	// states of the line fill engine
	typedef enum logic [1:0] {
		FILL_IDLE, // waiting for fill_start
		FILL_GATHER, // collecting beats into the line register
		FILL_WRITE // line goes into the RAM this cycle
	} fill_state_e;

endpackage

// ==== rtl/tmu_qpram.sv ====
// ------------------------------
// Quad-port texel RAM
// ------------------------------
module tmu_qpram #(
	parameter int depth = tmu_pkg::TEX_DEPTH // log2 of the capacity in bytes
) (
	input  logic                       sys_clk,

	input  logic                       re, // read strobe for all four ports
	input  logic [depth-1:0]           raa, // byte address, 16-bit aligned
	input  logic [depth-1:0]           rab,
	input  logic [depth-1:0]           rac,
	input  logic [depth-1:0]           rad,
	output logic [tmu_pkg::TEXEL_W-1:0] rda, // valid one cycle after re
	output logic [tmu_pkg::TEXEL_W-1:0] rdb,
	output logic [tmu_pkg::TEXEL_W-1:0] rdc,
	output logic [tmu_pkg::TEXEL_W-1:0] rdd,

	input  logic                       we, // line write strobe
	input  logic [depth-1:0]           wa, // byte address, 256-bit aligned
	input  logic [tmu_pkg::LINE_W-1:0]  wd // beat 0 sits in the top bits
);

	localparam int WORD_W = depth - tmu_pkg::LINE_OFS_W; // line index width
	localparam int SEL_W = tmu_pkg::LINE_OFS_W - 1; // texel index inside a line

	logic [tmu_pkg::LINE_W-1:0] line_a; // whole lines read back from the RAMs
	logic [tmu_pkg::LINE_W-1:0] line_b;
	logic [tmu_pkg::LINE_W-1:0] line_c;
	logic [tmu_pkg::LINE_W-1:0] line_d;

	logic [SEL_W-1:0] sel_a; // texel select, aligned with the RAM output
	logic [SEL_W-1:0] sel_b;
	logic [SEL_W-1:0] sel_c;
	logic [SEL_W-1:0] sel_d;

	// lowest texel address lives in the most significant slice of the line
	function automatic logic [tmu_pkg::TEXEL_W-1:0] pick(
		input logic [tmu_pkg::LINE_W-1:0] line,
		input logic [SEL_W-1:0]            sel
	);
		return line[tmu_pkg::LINE_W - 1 - sel * tmu_pkg::TEXEL_W -: tmu_pkg::TEXEL_W];
	endfunction

	always_ff @(posedge sys_clk) begin
		if (re) begin
			sel_a <= raa[tmu_pkg::LINE_OFS_W-1:1]; // bit 0 is the byte inside a texel
			sel_b <= rab[tmu_pkg::LINE_OFS_W-1:1];
			sel_c <= rac[tmu_pkg::LINE_OFS_W-1:1];
			sel_d <= rad[tmu_pkg::LINE_OFS_W-1:1];
		end
	end

	assign rda = pick(line_a, sel_a);
	assign rdb = pick(line_b, sel_b);
	assign rdc = pick(line_c, sel_c);
	assign rdd = pick(line_d, sel_d);

	// Both RAMs keep a full copy of the tile so any read port reaches any texel.
	// ram0 serves the top pair of the quad, ram1 the bottom pair
	tmu_tdpram #(
		.depth(WORD_W),
		.width(tmu_pkg::LINE_W)
	) ram0 (
		.sys_clk(sys_clk),
		.a      (we ? wa[depth-1:tmu_pkg::LINE_OFS_W] : raa[depth-1:tmu_pkg::LINE_OFS_W]),
		.we     (we),
		.re     (re),
		.di     (wd),
		.dout   (line_a),
		.a2     (we ? wa[depth-1:tmu_pkg::LINE_OFS_W] : rab[depth-1:tmu_pkg::LINE_OFS_W]),
		.we2    (1'b0), // the first port carries the write alone
		.re2    (re),
		.di2    (wd),
		.dout2  (line_b)
	);

	tmu_tdpram #(
		.depth(WORD_W),
		.width(tmu_pkg::LINE_W)
	) ram1 (
		.sys_clk(sys_clk),
		.a      (we ? wa[depth-1:tmu_pkg::LINE_OFS_W] : rac[depth-1:tmu_pkg::LINE_OFS_W]),
		.we     (we),
		.re     (re),
		.di     (wd),
		.dout   (line_c),
		.a2     (we ? wa[depth-1:tmu_pkg::LINE_OFS_W] : rad[depth-1:tmu_pkg::LINE_OFS_W]),
		.we2    (1'b0),
		.re2    (re),
		.di2    (wd),
		.dout2  (line_d)
	);

endmodule

// ==== rtl/tmu_tdpram.sv ====
// ------------------------------
// True dual-port RAM
// ------------------------------
module tmu_tdpram #(
	parameter int depth = 6, // log2 of the number of words
	parameter int width = 64 // word width in bits
) (
	input  logic             sys_clk,

	input  logic [depth-1:0] a, // first port address
	input  logic             we, // first port write enable
	input  logic             re, // first port read enable
	input  logic [width-1:0] di, // first port write data
	output logic [width-1:0] dout, // first port registered read data

	input  logic [depth-1:0] a2, // second port address
	input  logic             we2, // second port write enable
	input  logic             re2, // second port read enable
	input  logic [width-1:0] di2, // second port write data
	output logic [width-1:0] dout2 // second port registered read data
);

	logic [width-1:0] mem [2**depth]; // storage array, inferred as block RAM

	always_ff @(posedge sys_clk) begin
		if (we) begin
			mem[a] <= di; // write from the first port
		end
		if (we2) begin
			mem[a2] <= di2; // write from the second port
		end
	end

	// each output register holds its value until its port reads again
	always_ff @(posedge sys_clk) begin
		if (re) begin
			dout <= mem[a]; // read returns the old word on a same-cycle write
		end
		if (re2) begin
			dout2 <= mem[a2];
		end
	end

endmodule

// ==== rtl/tmu_texcache_top.sv ====
// ------------------------------
// Texel cache and filter slice
// ------------------------------
module tmu_texcache_top (
	input  logic                             sys_clk,
	input  logic                             rst_n,

	input  logic                             fill_start,
	input  logic [tmu_pkg::LINE_IDX_W-1:0]    fill_line,
	input  logic                             fill_valid,
	input  logic [tmu_pkg::BEAT_W-1:0]        fill_data,
	output logic                             fill_busy, // no fetch may be issued while high

	input  logic                             fetch,
	input  logic [tmu_pkg::TEX_SIDE_LOG2-1:0] tex_x,
	input  logic [tmu_pkg::TEX_SIDE_LOG2-1:0] tex_y,
	input  logic [tmu_pkg::FRAC_W-1:0]        frac_x,
	input  logic [tmu_pkg::FRAC_W-1:0]        frac_y,
	output logic                             out_valid,
	output logic [tmu_pkg::TEXEL_W-1:0]       out_pixel
);

	logic                          we; // line write from the fill engine
	logic [tmu_pkg::TEX_DEPTH-1:0] wa;
	logic [tmu_pkg::LINE_W-1:0]    wd;

	logic                          re; // quad read from the filter
	logic [tmu_pkg::TEX_DEPTH-1:0] raa;
	logic [tmu_pkg::TEX_DEPTH-1:0] rab;
	logic [tmu_pkg::TEX_DEPTH-1:0] rac;
	logic [tmu_pkg::TEX_DEPTH-1:0] rad;
	logic [tmu_pkg::TEXEL_W-1:0]   rda;
	logic [tmu_pkg::TEXEL_W-1:0]   rdb;
	logic [tmu_pkg::TEXEL_W-1:0]   rdc;
	logic [tmu_pkg::TEXEL_W-1:0]   rdd;

	tmu_line_fill u_line_fill (
		.sys_clk   (sys_clk),
		.rst_n     (rst_n),
		.fill_start(fill_start),
		.fill_line (fill_line),
		.fill_valid(fill_valid),
		.fill_data (fill_data),
		.fill_busy (fill_busy),
		.we        (we),
		.wa        (wa),
		.wd        (wd)
	);

	tmu_qpram #(
		.depth(tmu_pkg::TEX_DEPTH) // one whole tile
	) u_qpram (
		.sys_clk(sys_clk),
		.re     (re),
		.raa    (raa),
		.rab    (rab),
		.rac    (rac),
		.rad    (rad),
		.rda    (rda),
		.rdb    (rdb),
		.rdc    (rdc),
		.rdd    (rdd),
		.we     (we),
		.wa     (wa),
		.wd     (wd)
	);

	tmu_bilinear_filter u_filter (
		.sys_clk  (sys_clk),
		.rst_n    (rst_n),
		.fetch    (fetch),
		.tex_x    (tex_x),
		.tex_y    (tex_y),
		.frac_x   (frac_x),
		.frac_y   (frac_y),
		.re       (re),
		.raa      (raa),
		.rab      (rab),
		.rac      (rac),
		.rad      (rad),
		.rda      (rda),
		.rdb      (rdb),
		.rdc      (rdc),
		.rdd      (rdd),
		.out_valid(out_valid),
		.out_pixel(out_pixel)
	);

endmodule

// ==== test/tb_tmu_texcache.sv ====
// ------------------------------
// Texel cache slice testbench
// ------------------------------
module tb_tmu_texcache;

	localparam int MAX_GAP = 3; // longest pause between two fill beats
	localparam int FILL_CYCLES = 3 + tmu_pkg::BEATS_PER_LINE * (MAX_GAP + 1);
	localparam int ZERO_FETCHES = 48; // fetches spaced three cycles apart
	localparam int RAND_FETCHES = 300;
	localparam int TEST_CYCLES = 20 + 65 * FILL_CYCLES + ZERO_FETCHES * 4 + RAND_FETCHES + 60;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

	logic sys_clk;
	logic rst_n;
	logic fill_start;
	logic [tmu_pkg::LINE_IDX_W-1:0] fill_line;
	logic fill_valid;
	logic [tmu_pkg::BEAT_W-1:0] fill_data;
	logic fill_busy;
	logic fetch;
	logic [tmu_pkg::TEX_SIDE_LOG2-1:0] tex_x;
	logic [tmu_pkg::TEX_SIDE_LOG2-1:0] tex_y;
	logic [tmu_pkg::FRAC_W-1:0] frac_x;
	logic [tmu_pkg::FRAC_W-1:0] frac_y;
	logic out_valid;
	logic [tmu_pkg::TEXEL_W-1:0] out_pixel;

	integer seed; // state of $random
	int cycle_cnt; // posedges since time zero
	int mismatch_cnt; // wrong values
	int other_cnt; // protocol and ordering problems
	logic [tmu_pkg::TEXEL_W-1:0] shadow [1024]; // expected tile contents indexed by y*32+x
	logic [tmu_pkg::TEXEL_W-1:0] exp_q [$]; // pixels still owed by the DUT
	logic [tmu_pkg::TEXEL_W-1:0] popped;
	tmu_pkg::fill_state_e fill_st; // copy of the fill FSM state for the timeout report

	tmu_texcache_top u_tmu_texcache_top (.*);

	initial sys_clk = 1'b0;
	always #2 sys_clk = ~sys_clk; // period of 4

	always @(posedge sys_clk) cycle_cnt <= cycle_cnt + 1;

	// channels sit with red at bit 11 and green at bit 5 and blue at bit 0
	function automatic logic [tmu_pkg::TEXEL_W-1:0] ref_blend(
		input logic [tmu_pkg::TEXEL_W-1:0] a, b, c, d,
		input int wx, wy
	);
		int sh [3];
		int msk [3];
		int top;
		int bot;
		int res;
		logic [tmu_pkg::TEXEL_W-1:0] pix;
		sh = '{11, 5, 0};
		msk = '{31, 63, 31};
		pix = '0;
		for (int i = 0; i < 3; i++) begin
			top = ((a >> sh[i]) & msk[i]) * (64 - wx) + ((b >> sh[i]) & msk[i]) * wx;
			bot = ((c >> sh[i]) & msk[i]) * (64 - wx) + ((d >> sh[i]) & msk[i]) * wx;
			res = (top * (64 - wy) + bot * wy) >> 12; // truncating divide by 4096
			pix = pix | tmu_pkg::TEXEL_W'(res << sh[i]);
		end
		return pix;
	endfunction

	task automatic check_pixel(input string name, input logic [tmu_pkg::TEXEL_W-1:0] got,
		input logic [tmu_pkg::TEXEL_W-1:0] exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cycle_cnt);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("Mismatch %s: got %h expected %h at cycle %0d", name, got, exp, cycle_cnt);
		end
	endtask

	// new random texels for one line sent as four beats with random pauses
	task automatic load_line(input int line);
		logic [tmu_pkg::BEAT_W-1:0] beat;
		int base;
		int gap;
		base = line * 16;
		for (int j = 0; j < 16; j++) shadow[base + j] = $random(seed);
		fill_start = 1'b1;
		fill_line = line;
		@(negedge sys_clk);
		fill_start = 1'b0;
		check_bit("fill_busy", fill_busy, 1'b1); // rises the cycle after fill_start
		for (int b = 0; b < tmu_pkg::BEATS_PER_LINE; b++) begin
			gap = $random(seed) & MAX_GAP;
			repeat (gap) begin
				@(negedge sys_clk);
				check_bit("fill_busy", fill_busy, 1'b1);
			end
			beat = {shadow[base + 4*b], shadow[base + 4*b + 1],
				shadow[base + 4*b + 2], shadow[base + 4*b + 3]}; // lowest texel on top
			fill_valid = 1'b1;
			fill_data = beat;
			@(negedge sys_clk);
			fill_valid = 1'b0;
			check_bit("fill_busy", fill_busy, 1'b1); // still high in the write cycle
		end
		@(negedge sys_clk);
		check_bit("fill_busy", fill_busy, 1'b0); // two cycles after the last beat
	endtask

	// drives one fetch for a single cycle and queues the pixel it must return
	task automatic issue_fetch(input int x, input int y, input int fx, input int fy);
		int xn;
		int yn;
		xn = (x + 1) % 32; // neighbours wrap around the tile edge
		yn = (y + 1) % 32;
		fetch = 1'b1;
		tex_x = x;
		tex_y = y;
		frac_x = fx;
		frac_y = fy;
		exp_q.push_back(ref_blend(shadow[y*32 + x], shadow[y*32 + xn],
			shadow[yn*32 + x], shadow[yn*32 + xn], fx, fy));
		@(negedge sys_clk);
		fetch = 1'b0;
	endtask

	// every out_valid consumes the oldest queued pixel
	always @(negedge sys_clk) begin
		if (out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				other_cnt++;
				$display("out_valid seen with no fetch outstanding at cycle %0d", cycle_cnt);
			end else begin
				popped = exp_q.pop_front();
				check_pixel("out_pixel", out_pixel, popped);
			end
		end
	end

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		fill_st = u_tmu_texcache_top.u_line_fill.state;
		$display("timeout after %0d cycles with the fill FSM in %s and %0d pixels pending",
			cycle_cnt, fill_st.name(), exp_q.size());
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		seed = 32'h5761d0bd;
		cycle_cnt = 0;
		mismatch_cnt = 0;
		other_cnt = 0;
		rst_n = 1'b0;
		fill_start = 1'b0;
		fill_line = '0;
		fill_valid = 1'b0;
		fill_data = '0;
		fetch = 1'b0;
		tex_x = '0;
		tex_y = '0;
		frac_x = '0;
		frac_y = '0;
		repeat (2) @(negedge sys_clk);
		rst_n = 1'b1;

		repeat (6) begin // idle after reset
			@(negedge sys_clk);
			check_bit("fill_busy", fill_busy, 1'b0);
			check_bit("out_valid", out_valid, 1'b0);
		end

		for (int l = 0; l < 64; l++) load_line(l);

		for (int i = 0; i < ZERO_FETCHES; i++) begin // nearest texel with a latency of 3
			issue_fetch($random(seed) & 31, $random(seed) & 31, 0, 0);
			check_bit("out_valid", out_valid, 1'b0);
			@(negedge sys_clk);
			check_bit("out_valid", out_valid, 1'b0);
			@(negedge sys_clk);
			check_bit("out_valid", out_valid, 1'b1);
		end
		@(negedge sys_clk);

		for (int i = 0; i < RAND_FETCHES; i++) begin // back to back with edges forced now and then
			issue_fetch((i % 9 == 0) ? 31 : ($random(seed) & 31),
				(i % 7 == 0) ? 31 : ($random(seed) & 31),
				$random(seed) & 63, $random(seed) & 63);
		end
		repeat (4) @(negedge sys_clk);

		load_line(($random(seed) & 63)); // fresh data in one line
		for (int j = 0; j < 16; j++) begin
			issue_fetch((fill_line % 2) * 16 + j, fill_line / 2, 0, 0);
		end
		for (int j = 0; j < 16; j++) begin
			issue_fetch((fill_line % 2) * 16 + j, fill_line / 2, $random(seed) & 63, 0);
		end

		for (int i = 0; i < 8 && exp_q.size() != 0; i++) @(negedge sys_clk);
		repeat (4) @(negedge sys_clk); // any stray out_valid shows up here
		if (exp_q.size() != 0) begin
			other_cnt++;
			$display("%0d fetches never produced out_valid", exp_q.size());
		end

		$display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
rtl/tmu_pkg.sv
rtl/tmu_tdpram.sv
rtl/tmu_qpram.sv
rtl/tmu_line_fill.sv
rtl/tmu_bilinear_filter.sv
rtl/tmu_texcache_top.sv
test/tb_tmu_texcache.sv
